/* ttr_alu.f */
design/ttr_alu_pkg.sv
design/redundancy_ctrl.sv
design/ttr_issue.sv
design/opgroup_add.sv
design/opgroup_cmp.sv
design/result_arbiter.sv
design/ttr_vote.sv
design/ttr_alu_top.sv
bench/tb_ttr_alu.sv

/* Bender.yml */
package:
  name: ttr_alu

sources:
  - design/ttr_alu_pkg.sv
  - design/redundancy_ctrl.sv
  - design/ttr_issue.sv
  - design/opgroup_add.sv
  - design/opgroup_cmp.sv
  - design/result_arbiter.sv
  - design/ttr_vote.sv
  - design/ttr_alu_top.sv
  - target: test
    files:
      - bench/tb_ttr_alu.sv

/* bench/tb_ttr_alu.sv */
/*
 * Testbench for the TTR ALU
 * Random operations in single and triple mode against a reference model,
 * results matched by tag, random output back-pressure and a watchdog
 */
`timescale 1ns/10ps
`default_nettype none

module tb_ttr_alu;

  import ttr_alu_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 3;
  localparam int SEED         = 30238;
  localparam int NUM_TAGS     = 2 ** TAG_WIDTH;
  // Operations over all tests, in run order
  localparam int NUM_OPS        = 60 + 60 + 8 + 80 + 40 + 4 + 40;
  // About 20 cycles per operation, with margin for reset and drains
  localparam int TIMEOUT_CYCLES = (NUM_OPS + 8) * 20;

  logic     clk;
  logic     rst_n;
  logic     redundancy_en;
  logic     in_valid;
  logic     in_ready;
  op_req_t  in_req;
  logic     out_valid;
  logic     out_ready;
  out_res_t out_res;
  logic     busy;
  logic     fault;

  out_res_t             exp_res [NUM_TAGS];
  bit                   pending_tag [NUM_TAGS];
  logic [TAG_WIDTH-1:0] next_tag;
  int                   sent_cnt;
  int                   recv_cnt;
  int                   check_cnt;
  int                   error_cnt;
  int                   cycle_cnt;
  int                   last_xfer;
  bit                   triple_mode;
  bit                   stall_en;
  string                test_name;

  ttr_alu_top u_dut (
    .clk_i            ( clk           ),
    .rst_n_i          ( rst_n         ),
    .redundancy_en_i  ( redundancy_en ),
    .in_valid_i       ( in_valid      ),
    .in_ready_o       ( in_ready      ),
    .in_req_i         ( in_req        ),
    .out_valid_o      ( out_valid     ),
    .out_ready_i      ( out_ready     ),
    .out_res_o        ( out_res       ),
    .busy_o           ( busy          ),
    .fault_detected_o ( fault         )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // --------------------------------------------------------------------------
  // Reference model and stimulus helpers
  // --------------------------------------------------------------------------
  function automatic out_res_t ref_model(input op_req_t req);
    out_res_t res;
    longint   sa;
    longint   sb;
    longint   wide;
    sa = longint'($signed(req.operand_a));
    sb = longint'($signed(req.operand_b));
    case (req.op)
      ADD:     wide = sa + sb;
      SUB:     wide = sa - sb;
      MIN:     wide = (sa < sb) ? sa : sb;
      MAX:     wide = (sa < sb) ? sb : sa;
      SLT:     wide = (sa < sb) ? 1 : 0;
      EQ:      wide = (sa == sb) ? 1 : 0;
      default: wide = 0;
    endcase
    // Out of the 32-bit signed range
    res.status.overflow = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
    res.result          = wide[DATA_WIDTH-1:0];
    res.status.zero     = (res.result == '0);
    res.tag             = req.tag;
    return res;
  endfunction

  // Corner values show up often to hit overflow and equality
  function automatic logic [DATA_WIDTH-1:0] rand_operand();
    logic [DATA_WIDTH-1:0] val;
    case ($urandom % 8)
      0:       val = 32'h7fff_ffff;
      1:       val = 32'h8000_0000;
      2:       val = 32'hffff_ffff;
      3:       val = '0;
      default: val = $urandom;
    endcase
    return val;
  endfunction

  function automatic op_req_t rand_req(input bit with_cmp, input logic [TAG_WIDTH-1:0] tag);
    op_req_t req;
    req.operand_a = rand_operand();
    req.operand_b = ($urandom % 6 == 0) ? req.operand_a : rand_operand();
    if (with_cmp) begin
      req.op = op_e'(3'($urandom % 6));
    end else begin
      req.op = op_e'(3'($urandom % 2));
    end
    req.tag = tag;
    return req;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (pending_tag[t]) begin
        n++;
      end
    end
    return n;
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_op(input op_req_t req);
    bit accepted;
    int min_gap;
    while (pending_tag[req.tag]) begin
      @(negedge clk);
    end
    exp_res[req.tag]     = ref_model(req);
    pending_tag[req.tag] = 1'b1;
    in_valid = 1'b1;
    in_req   = req;
    accepted = 1'b0;
    while (!accepted) begin
      accepted = in_ready;
      @(negedge clk);
    end
    in_valid = 1'b0;
    // Issue stage holds an operation until its last copy has left
    min_gap = triple_mode ? 4 : 2;
    if (sent_cnt > 0 && cycle_cnt - last_xfer < min_gap) begin
      error_cnt++;
      $display("%s: operation accepted %0d cycles after the previous one, minimum is %0d",
               test_name, cycle_cnt - last_xfer, min_gap);
    end
    last_xfer = cycle_cnt;
    sent_cnt++;
  endtask

  task automatic send_batch(input int num, input bit with_cmp);
    for (int i = 0; i < num; i++) begin
      send_op(rand_req(with_cmp, next_tag));
      next_tag++;
    end
  endtask

  task automatic wait_idle();
    while (outstanding() != 0 || busy) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input int num, input int recv_before, input int errors_before);
    if (recv_cnt - recv_before != num) begin
      error_cnt++;
      $display("%s returned %0d results for %0d operations", test_name,
               recv_cnt - recv_before, num);
    end
    $display("Test %s: %0d operations, %0d errors", test_name, num,
             error_cnt - errors_before);
  endtask

  task automatic run_test(input string name, input int num, input bit with_cmp,
                          input bit stall);
    int recv_before;
    int errors_before;
    recv_before   = recv_cnt;
    errors_before = error_cnt;
    test_name     = name;
    stall_en      = stall;
    send_batch(num, with_cmp);
    wait_idle();
    stall_en = 1'b0;
    finish_test(num, recv_before, errors_before);
  endtask

  // Mode request changes while the last operations are still in flight
  task automatic switch_mode(input string name, input int num, input bit triple_on);
    int recv_before;
    int errors_before;
    bit busy_dropped;
    recv_before   = recv_cnt;
    errors_before = error_cnt;
    test_name     = name;
    busy_dropped  = 1'b0;
    send_batch(num, 1'b1);
    redundancy_en = triple_on;
    @(negedge clk);
    // Busy covers the pending switch and everything still in flight
    while (outstanding() != 0) begin
      if (!busy && !busy_dropped) begin
        busy_dropped = 1'b1;
        error_cnt++;
        $display("%s: busy_o low with %0d operations in flight", name, outstanding());
      end
      @(negedge clk);
    end
    wait_idle();
    triple_mode = triple_on;
    finish_test(num, recv_before, errors_before);
  endtask

  // --------------------------------------------------------------------------
  // Output side: back-pressure and scoreboard
  // --------------------------------------------------------------------------
  task automatic check_result(input out_res_t got);
    out_res_t want;
    recv_cnt++;
    if (!pending_tag[got.tag]) begin
      error_cnt++;
      $display("%s: result with tag %0d arrived with no operation outstanding",
               test_name, got.tag);
    end else begin
      check_cnt++;
      want = exp_res[got.tag];
      pending_tag[got.tag] = 1'b0;
      if (got !== want) begin
        error_cnt++;
        $display("Fail %s: tag %0d expected %h actual %h", test_name, got.tag, want, got);
      end
    end
  endtask

  initial begin : compare
    out_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (stall_en) begin
        out_ready = ($urandom % 2 == 0);
      end else begin
        out_ready = 1'b1;
      end
      if (fault) begin
        error_cnt++;
        $display("%s: fault_detected_o rose although all copies should agree", test_name);
      end
      // Valid and ready both hold through the next rising edge
      if (out_valid && out_ready) begin
        check_result(out_res);
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles in %s with %0d results outstanding",
             cycle_cnt, test_name, outstanding());
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin : main
    int errors_before;
    void'($urandom(SEED));
    rst_n         = 1'b0;
    redundancy_en = 1'b0;
    in_valid      = 1'b0;
    in_req        = '0;
    next_tag      = '0;
    sent_cnt      = 0;
    recv_cnt      = 0;
    check_cnt     = 0;
    error_cnt     = 0;
    last_xfer     = 0;
    triple_mode   = 1'b0;
    stall_en      = 1'b0;
    test_name     = "reset";
    for (int t = 0; t < NUM_TAGS; t++) begin
      pending_tag[t] = 1'b0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    errors_before = error_cnt;
    repeat (3) begin
      if (out_valid) begin
        error_cnt++;
        $display("reset: out_valid_o high before any input");
      end
      if (busy) begin
        error_cnt++;
        $display("reset: busy_o high before any input");
      end
      if (fault) begin
        error_cnt++;
        $display("reset: fault_detected_o high before any input");
      end
      @(negedge clk);
    end
    $display("Test reset: %0d errors", error_cnt - errors_before);

    run_test("single_addsub", 60, 1'b0, 1'b0);
    run_test("single_mixed", 60, 1'b1, 1'b0);
    switch_mode("to_triple", 8, 1'b1);
    run_test("triple_mixed", 80, 1'b1, 1'b0);
    run_test("triple_stall", 40, 1'b1, 1'b1);
    switch_mode("to_single", 4, 1'b0);
    run_test("single_stall", 40, 1'b1, 1'b1);

    $display("Checks: %0d sent, %0d results compared, %0d errors",
             sent_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/ttr_alu_top.sv */
/*
 * TTR ALU top level
 * Integer execution unit with optional triple time redundancy:
 * controller, issue stage, two operation groups, arbiter and vote
 */
`timescale 1ns/10ps
`default_nettype none

module ttr_alu_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  redundancy_en_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  ttr_alu_pkg::op_req_t  in_req_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output ttr_alu_pkg::out_res_t out_res_o,
  output logic                  busy_o,
  output logic                  fault_detected_o
);

  import ttr_alu_pkg::*;

  logic                  gated_valid;
  logic                  issue_ready_in;
  logic                  triple;
  logic                  issue_busy;
  logic                  vote_busy;
  logic                  issue_valid;
  logic                  issue_ready;
  issue_t                issue_data;
  group_e                issue_grp;
  logic [NUM_GROUPS-1:0] grp_in_valid;
  logic [NUM_GROUPS-1:0] grp_in_ready;
  logic [NUM_GROUPS-1:0] grp_out_valid;
  logic [NUM_GROUPS-1:0] grp_out_ready;
  group_res_t            grp_res [NUM_GROUPS];
  logic                  arb_valid;
  logic                  arb_ready;
  group_res_t            arb_res;
  logic                  lock;

  redundancy_ctrl i_ctrl (
    .clk_i,
    .rst_n_i,
    .redundancy_en_i,
    .in_valid_i,
    .in_ready_o,
    .issue_valid_o ( gated_valid    ),
    .issue_ready_i ( issue_ready_in ),
    .issue_busy_i  ( issue_busy     ),
    .vote_busy_i   ( vote_busy      ),
    .triple_o      ( triple         ),
    .busy_o
  );

  ttr_issue i_issue (
    .clk_i,
    .rst_n_i,
    .triple_i ( triple         ),
    .valid_i  ( gated_valid    ),
    .ready_o  ( issue_ready_in ),
    .req_i    ( in_req_i       ),
    .valid_o  ( issue_valid    ),
    .ready_i  ( issue_ready    ),
    .issue_o  ( issue_data     ),
    .busy_o   ( issue_busy     )
  );

  // ------------------------------------------------------------------------
  // Dispatch to the group that executes the op
  // ------------------------------------------------------------------------
  assign issue_grp   = get_group(issue_data.req.op);
  assign issue_ready = grp_in_ready[issue_grp];

  for (genvar g = 0; g < NUM_GROUPS; g++) begin : gen_dispatch
    assign grp_in_valid[g] = issue_valid & (issue_grp == group_e'(g));
  end

  opgroup_add i_add (
    .clk_i,
    .rst_n_i,
    .valid_i ( grp_in_valid[GRP_ADD]  ),
    .ready_o ( grp_in_ready[GRP_ADD]  ),
    .issue_i ( issue_data             ),
    .valid_o ( grp_out_valid[GRP_ADD] ),
    .ready_i ( grp_out_ready[GRP_ADD] ),
    .res_o   ( grp_res[GRP_ADD]       )
  );

  opgroup_cmp i_cmp (
    .clk_i,
    .rst_n_i,
    .valid_i ( grp_in_valid[GRP_CMP]  ),
    .ready_o ( grp_in_ready[GRP_CMP]  ),
    .issue_i ( issue_data             ),
    .valid_o ( grp_out_valid[GRP_CMP] ),
    .ready_i ( grp_out_ready[GRP_CMP] ),
    .res_o   ( grp_res[GRP_CMP]       )
  );

  result_arbiter #(
    .NumIn  ( NUM_GROUPS  ),
    .data_t ( group_res_t )
  ) i_arbiter (
    .clk_i,
    .rst_n_i,
    .valid_i ( grp_out_valid ),
    .ready_o ( grp_out_ready ),
    .data_i  ( grp_res       ),
    .lock_i  ( lock          ),
    .valid_o ( arb_valid     ),
    .ready_i ( arb_ready     ),
    .data_o  ( arb_res       )
  );

  ttr_vote i_vote (
    .clk_i,
    .rst_n_i,
    .valid_i          ( arb_valid   ),
    .ready_o          ( arb_ready   ),
    .res_i            ( arb_res     ),
    .lock_o           ( lock        ),
    .busy_o           ( vote_busy   ),
    .valid_o          ( out_valid_o ),
    .ready_i          ( out_ready_i ),
    .res_o            ( out_res_o   ),
    .fault_detected_o
  );

endmodule

`default_nettype wire

/* design/ttr_vote.sv */
/*
 * Majority vote
 * Keeps copies 0 and 1, votes bitwise with the last copy and registers
 * the result; a lone copy in single mode goes through the same register
 */
`timescale 1ns/10ps
`default_nettype none

module ttr_vote (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  input  ttr_alu_pkg::group_res_t res_i,
  output logic                    lock_o,
  output logic                    busy_o,
  output logic                    valid_o,
  input  logic                    ready_i,
  output ttr_alu_pkg::out_res_t   res_o,
  output logic                    fault_detected_o
);

  import ttr_alu_pkg::*;

  localparam int unsigned VoteW = DATA_WIDTH + $bits(status_t);

  logic             out_valid_q;
  logic             lock_q;
  logic             fault_q;
  logic             accept;
  logic             single;
  logic             mismatch;
  logic [VoteW-1:0] in_bits;
  logic [VoteW-1:0] copy0_q;
  logic [VoteW-1:0] copy1_q;
  logic [VoteW-1:0] maj_bits;
  out_res_t         out_q;

  assign accept  = valid_i & ready_o;
  assign ready_o = ~out_valid_q | ready_i;
  assign in_bits = {res_i.result, res_i.status};
  // Copy 0 marked last only happens in single mode
  assign single  = (res_i.copy == '0);

  assign maj_bits = (copy0_q & copy1_q) | (copy0_q & in_bits) | (copy1_q & in_bits);
  assign mismatch = |((copy0_q ^ copy1_q) | (copy0_q ^ in_bits));

  // ------------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
      lock_q      <= 1'b0;
      fault_q     <= 1'b0;
    end else begin
      fault_q <= 1'b0;
      if (out_valid_q && ready_i) begin
        out_valid_q <= 1'b0;
      end
      if (accept) begin
        if (res_i.last) begin
          out_valid_q <= 1'b1;
          lock_q      <= 1'b0;
          fault_q     <= ~single & mismatch;
        end else begin
          lock_q <= 1'b1;
        end
      end
    end
  end

  // Copy storage and output register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (!res_i.last) begin
        if (single) begin
          copy0_q <= in_bits;
        end else begin
          copy1_q <= in_bits;
        end
      end else begin
        {out_q.result, out_q.status} <= single ? in_bits : maj_bits;
        out_q.tag <= res_i.tag;
      end
    end
  end

  assign lock_o           = lock_q;
  assign busy_o           = valid_i | lock_q | out_valid_q;
  assign valid_o          = out_valid_q;
  assign res_o            = out_q;
  assign fault_detected_o = fault_q;

endmodule

`default_nettype wire

/* design/result_arbiter.sv */
/*
 * Result arbiter
 * Round-robin choice among the group outputs; a lock input keeps the
 * last winner granted while a repeated operation drains
 */
`timescale 1ns/10ps
`default_nettype none

module result_arbiter #(
  parameter int unsigned NumIn  = 2,
  parameter type         data_t = logic
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [NumIn-1:0] valid_i,
  output logic [NumIn-1:0] ready_o,
  input  data_t            data_i [NumIn],
  input  logic             lock_i,
  output logic             valid_o,
  input  logic             ready_i,
  output data_t            data_o
);

  localparam int unsigned IdxW = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxW-1:0] rr_q;
  logic [IdxW-1:0] last_q;
  logic [IdxW-1:0] sel;

  // First valid input at or after the pointer
  always_comb begin : pick
    int unsigned cand;
    logic        found;
    found = 1'b0;
    sel   = rr_q;
    for (int unsigned k = 0; k < NumIn; k++) begin
      cand = (int'(rr_q) + k) % NumIn;
      if (!found && valid_i[cand]) begin
        found = 1'b1;
        sel   = IdxW'(cand);
      end
    end
    if (lock_i) begin
      sel = last_q;
    end
  end

  assign valid_o = valid_i[sel];
  assign data_o  = data_i[sel];

  always_comb begin
    ready_o = '0;
    ready_o[sel] = ready_i;
  end

  // ------------------------------------------------------------------------
  // Pointer moves past the winner after each transfer
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q   <= '0;
      last_q <= '0;
    end else if (valid_o && ready_i) begin
      last_q <= sel;
      if (int'(sel) == NumIn - 1) begin
        rr_q <= '0;
      end else begin
        rr_q <= sel + IdxW'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* design/opgroup_cmp.sv */
/*
 * Compare group
 * Signed MIN, MAX, SLT and EQ in a single register stage
 */
`timescale 1ns/10ps
`default_nettype none

module opgroup_cmp (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  input  ttr_alu_pkg::issue_t     issue_i,
  output logic                    valid_o,
  input  logic                    ready_i,
  output ttr_alu_pkg::group_res_t res_o
);

  import ttr_alu_pkg::*;

  logic                  valid_q;
  logic                  a_lt_b;
  logic [DATA_WIDTH-1:0] opa;
  logic [DATA_WIDTH-1:0] opb;
  logic [DATA_WIDTH-1:0] result;
  group_res_t            res_q;

  assign opa    = issue_i.req.operand_a;
  assign opb    = issue_i.req.operand_b;
  assign a_lt_b = $signed(opa) < $signed(opb);

  always_comb begin
    case (issue_i.req.op)
      MIN:     result = a_lt_b ? opa : opb;
      MAX:     result = a_lt_b ? opb : opa;
      SLT:     result = DATA_WIDTH'(a_lt_b);
      EQ:      result = DATA_WIDTH'(opa == opb);
      default: result = '0;
    endcase
  end

  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Compares never overflow
  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      res_q.result          <= result;
      res_q.status.overflow <= 1'b0;
      res_q.status.zero     <= (result == '0);
      res_q.tag             <= issue_i.req.tag;
      res_q.copy            <= issue_i.copy;
      res_q.last            <= issue_i.last;
    end
  end

  assign valid_o = valid_q;
  assign res_o   = res_q;

endmodule

`default_nettype wire

/* design/opgroup_add.sv */
/*
 * Add group
 * Two-stage ADD/SUB pipeline; stage one forms the sum, stage two
 * derives signed overflow and the zero flag
 */
`timescale 1ns/10ps
`default_nettype none

module opgroup_add (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  input  ttr_alu_pkg::issue_t     issue_i,
  output logic                    valid_o,
  input  logic                    ready_i,
  output ttr_alu_pkg::group_res_t res_o
);

  import ttr_alu_pkg::*;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] sum;
    logic                  a_msb;
    logic                  b_msb;
    logic                  is_sub;
    logic [TAG_WIDTH-1:0]  tag;
    logic [COPY_WIDTH-1:0] copy;
    logic                  last;
  } stage1_t;

  logic       valid1_q;
  logic       valid2_q;
  logic       advance;
  stage1_t    s1_d;
  stage1_t    s1_q;
  group_res_t res_d;
  group_res_t res_q;

  // Both stages move together
  assign advance = ~valid2_q | ready_i;

  // Stage one
  assign s1_d.is_sub = (issue_i.req.op == SUB);
  assign s1_d.sum    = s1_d.is_sub ? issue_i.req.operand_a - issue_i.req.operand_b
                                   : issue_i.req.operand_a + issue_i.req.operand_b;
  assign s1_d.a_msb  = issue_i.req.operand_a[DATA_WIDTH-1];
  assign s1_d.b_msb  = issue_i.req.operand_b[DATA_WIDTH-1];
  assign s1_d.tag    = issue_i.req.tag;
  assign s1_d.copy   = issue_i.copy;
  assign s1_d.last   = issue_i.last;

  // Stage two: overflow when the sign of the result cannot be right
  assign res_d.result          = s1_q.sum;
  assign res_d.status.overflow = (s1_q.a_msb ^ s1_q.b_msb ^ ~s1_q.is_sub) &
                                 (s1_q.sum[DATA_WIDTH-1] ^ s1_q.a_msb);
  assign res_d.status.zero     = (s1_q.sum == '0);
  assign res_d.tag             = s1_q.tag;
  assign res_d.copy            = s1_q.copy;
  assign res_d.last            = s1_q.last;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid1_q <= 1'b0;
      valid2_q <= 1'b0;
    end else if (advance) begin
      valid1_q <= valid_i;
      valid2_q <= valid1_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_q  <= s1_d;
      res_q <= res_d;
    end
  end

  assign ready_o = advance;
  assign valid_o = valid2_q;
  assign res_o   = res_q;

endmodule

`default_nettype wire

/* design/ttr_issue.sv */
/*
 * Issue stage
 * Registers one operation and sends it on as one copy, or as three
 * numbered copies in triple mode, with the last flag on the final one
 */
`timescale 1ns/10ps
`default_nettype none

module ttr_issue (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 triple_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  ttr_alu_pkg::op_req_t req_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output ttr_alu_pkg::issue_t  issue_o,
  output logic                 busy_o
);

  import ttr_alu_pkg::*;

  logic                  valid_q;
  op_req_t               op_q;
  logic [COPY_WIDTH-1:0] copy_q;
  logic                  last_copy;

  // Single mode ends after copy 0
  assign last_copy = ~triple_i | (copy_q == COPY_WIDTH'(2));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      copy_q  <= '0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
      copy_q  <= '0;
    end else if (valid_q && ready_i) begin
      if (last_copy) begin
        valid_q <= 1'b0;
      end else begin
        copy_q <= copy_q + COPY_WIDTH'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      op_q <= req_i;
    end
  end

  // One operation at a time
  assign ready_o = ~valid_q;
  assign valid_o = valid_q;
  assign busy_o  = valid_q;

  assign issue_o.req  = op_q;
  assign issue_o.copy = copy_q;
  assign issue_o.last = last_copy;

endmodule

`default_nettype wire

/* design/redundancy_ctrl.sv */
/*
 * Redundancy controller
 * Owns the redundancy mode, holds off new input while a mode change
 * is pending and flips the mode once the unit has gone idle
 */
`timescale 1ns/10ps
`default_nettype none

module redundancy_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic redundancy_en_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  output logic issue_valid_o,
  input  logic issue_ready_i,
  input  logic issue_busy_i,
  input  logic vote_busy_i,
  output logic triple_o,
  output logic busy_o
);

  logic req_q;
  logic triple_q;
  logic pending;
  logic idle;

  // Requested mode differs from the one in use
  assign pending = req_q ^ triple_q;
  assign idle    = ~issue_busy_i & ~vote_busy_i;

  // Input is blocked until the switch has happened
  assign in_ready_o    = issue_ready_i & ~pending;
  assign issue_valid_o = in_valid_i & ~pending;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q    <= 1'b0;
      triple_q <= 1'b0;
    end else begin
      req_q <= redundancy_en_i;
      if (pending && idle) begin
        triple_q <= req_q;
      end
    end
  end

  assign triple_o = triple_q;
  assign busy_o   = ~idle | pending;

endmodule

`default_nettype wire

/* design/ttr_alu_pkg.sv */
/*
 * TTR ALU package
 * Widths, operation and group encodings, and the structs that carry
 * operations and results between the stages of the unit
 */
`default_nettype none

package ttr_alu_pkg;

  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned TAG_WIDTH  = 4;
  localparam int unsigned NUM_GROUPS = 2;
  localparam int unsigned COPY_WIDTH = 2;

  typedef enum logic [2:0] {ADD, SUB, MIN, MAX, SLT, EQ} op_e;

  typedef enum logic {GRP_ADD, GRP_CMP} group_e;

  // Operation group that executes a given op
  function automatic group_e get_group(op_e op);
    case (op)
      ADD, SUB: return GRP_ADD;
      default:  return GRP_CMP;
    endcase
  endfunction

  typedef struct packed {
    logic overflow;
    logic zero;
  } status_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;
    op_e                   op;
    logic [TAG_WIDTH-1:0]  tag;
  } op_req_t;

  // One numbered copy of an operation
  typedef struct packed {
    op_req_t               req;
    logic [COPY_WIDTH-1:0] copy;
    logic                  last;
  } issue_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] result;
    status_t               status;
    logic [TAG_WIDTH-1:0]  tag;
    logic [COPY_WIDTH-1:0] copy;
    logic                  last;
  } group_res_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] result;
    status_t               status;
    logic [TAG_WIDTH-1:0]  tag;
  } out_res_t;

endpackage

`default_nettype wire
